// File: list.f
src/loop_pkg.sv
src/loop_regs.sv
src/iter_dispatch.sv
src/loop_worker.sv
src/loop_top.sv
testbench/loop_checker.sv
testbench/tb_loop_top.sv

// File: Bender.yml
package:
  name: loop_dispatch

sources:
  - files:
      - src/loop_pkg.sv
      - src/loop_regs.sv
      - src/iter_dispatch.sv
      - src/loop_worker.sv
      - src/loop_top.sv
  - target: test
    files:
      - testbench/loop_checker.sv
      - testbench/tb_loop_top.sv

// File: testbench/tb_loop_top.sv
`default_nettype none

module tb_loop_top;

	localparam int N_CORE       = 4;
	localparam int BUS_TIMEOUT  = 20;
	localparam int DONE_TIMEOUT = 5000;

	logic              clk;
	logic              rst_n;
	loop_pkg::wb_req_t wb_req;
	loop_pkg::wb_rsp_t wb_rsp;
	logic              done;

	loop_top #(
		.N_CORE(N_CORE)
	) u_dut (
		.clk,
		.rst_n,
		.wb_req,
		.wb_rsp,
		.done
	);

	always #5 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		string line;
		assert (act_val == exp_val) else begin
			line = $sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, exp_val, act_val);
			stop_run(line);
		end
	endtask

	// Master holds the request until the ack comes back
	task automatic wb_access(input logic we, input loop_pkg::wb_adr_t adr,
		input loop_pkg::wb_dat_t wdat, output loop_pkg::wb_dat_t rdat);
		int n;
		n = 0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hF};
		@(posedge clk);
		while (!wb_rsp.ack) begin
			if (n >= BUS_TIMEOUT) begin
				stop_run($sformatf("No bus ack for address 0x%02h within the timeout", adr));
			end else begin
				@(posedge clk);
				n++;
			end
		end
		rdat = wb_rsp.dat;
		wb_req <= '0;
	endtask

	task automatic wb_write(input loop_pkg::wb_adr_t adr, input loop_pkg::wb_dat_t dat);
		loop_pkg::wb_dat_t unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input loop_pkg::wb_adr_t adr, output loop_pkg::wb_dat_t dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(posedge clk);
		while (!done) begin
			if (n >= DONE_TIMEOUT) begin
				stop_run("Loop did not finish within the timeout");
			end else begin
				@(posedge clk);
				n++;
			end
		end
	endtask

	// Ascending unless the stride is negative
	function automatic logic beyond_limit(input loop_pkg::idx_t i, input loop_pkg::idx_t stride,
		input loop_pkg::idx_t limit);
		if (stride < 0) begin
			return i <= limit;
		end else begin
			return i >= limit;
		end
	endfunction

	// Walk the arithmetic sequence until it leaves the range
	task automatic expected_totals(input loop_pkg::idx_t start, input loop_pkg::idx_t stride,
		input loop_pkg::idx_t limit, output logic [31:0] cnt, output loop_pkg::acc_t sum);
		loop_pkg::idx_t i;
		i   = start;
		cnt = '0;
		sum = '0;
		while (!beyond_limit(i, stride, limit)) begin
			cnt = cnt + 32'd1;
			sum = sum + loop_pkg::acc_t'(i);
			i   = i + stride;
		end
	endtask

	task automatic start_loop(input loop_pkg::idx_t start, input loop_pkg::idx_t stride,
		input loop_pkg::idx_t limit);
		wb_write(loop_pkg::REG_START, start);
		wb_write(loop_pkg::REG_STRIDE, stride);
		wb_write(loop_pkg::REG_LIMIT, limit);
		wb_write(loop_pkg::REG_CTRL, 32'h1);
	endtask

	// Totals over all cores against the model
	task automatic check_loop(input string name, input loop_pkg::idx_t start,
		input loop_pkg::idx_t stride, input loop_pkg::idx_t limit);
		logic [31:0]       exp_cnt;
		logic [31:0]       got_cnt;
		loop_pkg::acc_t    exp_sum;
		loop_pkg::acc_t    got_sum;
		loop_pkg::wb_dat_t rd;
		expected_totals(start, stride, limit, exp_cnt, exp_sum);
		got_cnt = '0;
		got_sum = '0;
		for (int i = 0; i < N_CORE; i++) begin
			wb_read(loop_pkg::REG_CNT_BASE + 8'(4 * i), rd);
			got_cnt = got_cnt + rd;
			wb_read(loop_pkg::REG_SUM_BASE + 8'(4 * i), rd);
			got_sum = got_sum + rd;
		end
		check_value({name, " count"}, exp_cnt, got_cnt);
		check_value({name, " sum"}, exp_sum, got_sum);
		wb_read(loop_pkg::REG_STATUS, rd);
		check_value({name, " status"}, 32'h2, rd);
	endtask

	task automatic run_loop(input string name, input loop_pkg::idx_t start,
		input loop_pkg::idx_t stride, input loop_pkg::idx_t limit);
		start_loop(start, stride, limit);
		wait_done();
		check_loop(name, start, stride, limit);
	endtask

	task automatic check_cores_zero(input string name);
		loop_pkg::wb_dat_t rd;
		for (int i = 0; i < N_CORE; i++) begin
			wb_read(loop_pkg::REG_SUM_BASE + 8'(4 * i), rd);
			check_value($sformatf("%s sum core %0d", name, i), 32'h0, rd);
			wb_read(loop_pkg::REG_CNT_BASE + 8'(4 * i), rd);
			check_value($sformatf("%s count core %0d", name, i), 32'h0, rd);
		end
	endtask

	// Checker assertions count their failures
	always @(posedge clk) begin
		if (u_dut.u_checker.fail_cnt != 0) begin
			stop_run("A bus or completion assertion failed in the checker");
		end
	end

	initial begin
		loop_pkg::wb_dat_t rd;
		loop_pkg::idx_t    r_start;
		loop_pkg::idx_t    r_stride;
		loop_pkg::idx_t    r_limit;
		loop_pkg::idx_t    span;
		clk    = 1'b0;
		rst_n  = 1'b0;
		wb_req = '0;
		void'($urandom(32'hde0c_48f3));
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		check_value("reset done", 32'h0, {31'b0, done});
		wb_read(loop_pkg::REG_STATUS, rd);
		check_value("reset status", 32'h0, rd);
		check_cores_zero("reset");

		wb_write(loop_pkg::REG_START, 32'h0000_1234);
		wb_write(loop_pkg::REG_STRIDE, 32'hFFFF_FFFB);
		wb_write(loop_pkg::REG_LIMIT, 32'h8000_0010);
		wb_read(loop_pkg::REG_START, rd);
		check_value("readback start", 32'h0000_1234, rd);
		wb_read(loop_pkg::REG_STRIDE, rd);
		check_value("readback stride", 32'hFFFF_FFFB, rd);
		wb_read(loop_pkg::REG_LIMIT, rd);
		check_value("readback limit", 32'h8000_0010, rd);

		run_loop("ascending", 3, 2, 60);
		run_loop("descending", 100, -7, -45);

		for (int t = 0; t < 8; t++) begin
			r_start  = $urandom_range(400);
			r_start  = r_start - 200;
			r_stride = $urandom_range(9, 1);
			span     = $urandom_range(300);
			if ($urandom_range(1) == 1) begin
				r_stride = -r_stride;
				r_limit  = r_start - span;
			end else begin
				r_limit = r_start + span;
			end
			run_loop($sformatf("random %0d", t), r_start, r_stride, r_limit);
		end

		// Start already past the limit
		start_loop(10, 1, 5);
		wait_done();
		check_cores_zero("empty");
		check_loop("empty", 10, 1, 5);

		// Second go lands while the first loop runs
		start_loop(0, 1, 300);
		wb_read(loop_pkg::REG_STATUS, rd);
		check_value("busy status", 32'h1, rd);
		// Other bounds would show up in the totals if this go restarted the loop
		wb_write(loop_pkg::REG_START, 32'd1000);
		wb_write(loop_pkg::REG_LIMIT, 32'd1010);
		wb_write(loop_pkg::REG_CTRL, 32'h1);
		wait_done();
		check_loop("go while busy", 0, 1, 300);
		run_loop("restart", 50, -3, -20);

		if (u_dut.u_checker.fail_cnt == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			stop_run("A bus or completion assertion failed in the checker");
		end
	end

endmodule

`default_nettype wire

// File: testbench/loop_checker.sv
`default_nettype none

module loop_checker (
	input logic              clk,
	input logic              rst_n,
	input loop_pkg::wb_req_t wb_req,
	input loop_pkg::wb_rsp_t wb_rsp,
	input logic              fork_pulse,
	input logic              done
);

	int fail_ack_req = 0;
	int fail_ack_len = 0;
	int fail_done    = 0;
	int fail_fork    = 0;
	int fail_cnt;

	assign fail_cnt = fail_ack_req + fail_ack_len + fail_done + fail_fork;

	// Ack answers a request seen in the cycle before
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
	else begin
		$error("ack without a request in the previous cycle");
		fail_ack_req = fail_ack_req + 1;
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		$error("ack held high for two cycles");
		fail_ack_len = fail_ack_len + 1;
	end

	// Only a new fork may clear done
	done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(done) |-> fork_pulse)
	else begin
		$error("done dropped without a fork");
		fail_done = fail_done + 1;
	end

	fork_single: assert property (@(posedge clk) disable iff (!rst_n)
		fork_pulse |=> !fork_pulse)
	else begin
		$error("fork longer than one cycle");
		fail_fork = fail_fork + 1;
	end

endmodule

bind loop_top loop_checker u_checker (
	.clk        (clk),
	.rst_n      (rst_n),
	.wb_req     (wb_req),
	.wb_rsp     (wb_rsp),
	.fork_pulse (fork_pulse),
	.done       (done)
);

`default_nettype wire

// File: src/loop_top.sv
`default_nettype none

module loop_top #(
	parameter int N_CORE = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  loop_pkg::wb_req_t wb_req,
	output loop_pkg::wb_rsp_t wb_rsp,
	output logic              done
);

	loop_pkg::loop_cfg_t         cfg;
	logic                        fork_pulse;
	logic                        all_done;
	logic                        stride_neg;
	logic [N_CORE-1:0]           req;
	logic [N_CORE-1:0]           finished;
	loop_pkg::idx_t [N_CORE-1:0] idx;
	loop_pkg::acc_t [N_CORE-1:0] sums;
	loop_pkg::cnt_t [N_CORE-1:0] counts;

	assign stride_neg = cfg.stride[$bits(loop_pkg::idx_t)-1];

	// Loop ends when every core has hit the limit
	assign all_done = &finished;

	loop_regs #(
		.N_CORE(N_CORE)
	) u_regs (
		.clk,
		.rst_n,
		.wb_req,
		.wb_rsp,
		.cfg,
		.fork_pulse,
		.all_done,
		.sums,
		.counts,
		.done
	);

	iter_dispatch #(
		.N_CORE(N_CORE)
	) u_dispatch (
		.clk,
		.rst_n,
		.fork_pulse,
		.cfg,
		.req,
		.idx
	);

	for (genvar i = 0; i < N_CORE; i++) begin : g_worker
		loop_worker u_worker (
			.clk,
			.rst_n,
			.fork_pulse,
			.limit      (cfg.limit),
			.stride_neg,
			.req        (req[i]),
			.idx        (idx[i]),
			.sum        (sums[i]),
			.count      (counts[i]),
			.finished   (finished[i])
		);
	end

endmodule

`default_nettype wire

// File: src/loop_worker.sv
`default_nettype none

module loop_worker (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           fork_pulse,
	input  loop_pkg::idx_t limit,
	input  logic           stride_neg,
	output logic           req,
	input  loop_pkg::idx_t idx,
	output loop_pkg::acc_t sum,
	output loop_pkg::cnt_t count,
	output logic           finished
);

	loop_pkg::worker_state_e state;
	loop_pkg::worker_state_e state_nxt;
	logic [1:0]              wait_cnt;
	logic                    past;
	logic                    take;

	// Termination rule, zero stride counts as ascending
	assign past = stride_neg ? (idx <= limit) : (idx >= limit);

	// One request per visit to W_FETCH
	assign req      = (state == loop_pkg::W_FETCH);
	assign take     = req && !past;
	assign finished = (state == loop_pkg::W_DONE);

	always_comb begin
		state_nxt = state;
		case (state)
			loop_pkg::W_IDLE,
			loop_pkg::W_DONE: begin
				if (fork_pulse) begin
					state_nxt = loop_pkg::W_FETCH;
				end
			end
			loop_pkg::W_FETCH: begin
				if (past) begin
					state_nxt = loop_pkg::W_DONE;
				end else begin
					state_nxt = loop_pkg::W_WORK;
				end
			end
			loop_pkg::W_WORK: begin
				// Last work cycle
				if (wait_cnt == 2'd0) begin
					state_nxt = loop_pkg::W_FETCH;
				end
			end
			default: state_nxt = loop_pkg::W_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= loop_pkg::W_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Work time is idx[1:0] + 1 cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= 2'd0;
		end else if (take) begin
			wait_cnt <= idx[1:0];
		end else if (state == loop_pkg::W_WORK && wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum   <= '0;
			count <= '0;
		end else if (fork_pulse && (state == loop_pkg::W_IDLE || finished)) begin
			// Fresh loop, drop the previous results
			sum   <= '0;
			count <= '0;
		end else if (take) begin
			sum   <= sum + loop_pkg::acc_t'(idx);
			count <= count + loop_pkg::cnt_t'(1);
		end
	end

endmodule

`default_nettype wire

// File: src/iter_dispatch.sv
`default_nettype none

module iter_dispatch #(
	parameter int N_CORE = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        fork_pulse,
	input  loop_pkg::loop_cfg_t         cfg,
	input  logic [N_CORE-1:0]           req,
	output loop_pkg::idx_t [N_CORE-1:0] idx
);

	// Enough bits to count every requester at once
	localparam int CNT_W = $clog2(N_CORE + 1);

	loop_pkg::idx_t   counter;
	loop_pkg::idx_t   stride;
	loop_pkg::idx_t   step [N_CORE+1];
	logic [CNT_W-1:0] prefix [N_CORE+1];

	// step[i] is the i-th value ahead of the counter
	always_comb begin
		step[0] = counter;
		for (int i = 1; i <= N_CORE; i++) begin
			step[i] = step[i-1] + stride;
		end
	end

	// Number of requesting cores below each core
	always_comb begin
		prefix[0] = '0;
		for (int k = 0; k < N_CORE; k++) begin
			prefix[k+1] = prefix[k] + CNT_W'(req[k]);
		end
	end

	// Requesters get consecutive values in core order
	always_comb begin
		for (int k = 0; k < N_CORE; k++) begin
			idx[k] = step[prefix[k]];
		end
	end

	// Load on fork, else skip past everything handed out this cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			counter <= '0;
			stride  <= '0;
		end else if (fork_pulse) begin
			counter <= cfg.start;
			stride  <= cfg.stride;
		end else begin
			counter <= step[prefix[N_CORE]];
		end
	end

endmodule

`default_nettype wire

// File: src/loop_regs.sv
`default_nettype none

module loop_regs #(
	parameter int N_CORE = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  loop_pkg::wb_req_t           wb_req,
	output loop_pkg::wb_rsp_t           wb_rsp,
	output loop_pkg::loop_cfg_t         cfg,
	output logic                        fork_pulse,
	input  logic                        all_done,
	input  loop_pkg::acc_t [N_CORE-1:0] sums,
	input  loop_pkg::cnt_t [N_CORE-1:0] counts,
	output logic                        done
);

	// Word slot inside a per-core result window
	localparam int SLOT_W = $clog2(loop_pkg::MAX_CORE);
	localparam int WIN_LO = SLOT_W + 2;

	loop_pkg::loop_cfg_t shadow;
	logic                ack_q;
	loop_pkg::wb_dat_t   dat_q;
	logic                busy;
	logic                go_pend;
	logic                access;
	logic                wr_en;
	logic                go_wr;
	logic [SLOT_W-1:0]   slot;
	logic                slot_ok;
	loop_pkg::wb_dat_t   rd_data;

	// Byte-lane merge for configuration writes
	function automatic loop_pkg::idx_t merge_bytes(
		input loop_pkg::idx_t    old_val,
		input loop_pkg::wb_dat_t wr_dat,
		input loop_pkg::wb_sel_t sel
	);
		loop_pkg::idx_t res;
		res = old_val;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = wr_dat[8*b +: 8];
			end
		end
		return res;
	endfunction

	// New access only when the previous ack has gone
	assign access = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_en  = access && wb_req.we;
	assign go_wr  = wr_en && (wb_req.adr == loop_pkg::REG_CTRL)
		&& wb_req.sel[0] && wb_req.dat[0];

	assign slot    = wb_req.adr[WIN_LO-1:2];
	assign slot_ok = (wb_req.adr[1:0] == 2'b00) && (int'(slot) < N_CORE);

	assign wb_rsp = '{ack: ack_q, dat: dat_q};

	always_comb begin
		rd_data = '0;
		case (wb_req.adr)
			loop_pkg::REG_START:  rd_data = shadow.start;
			loop_pkg::REG_STRIDE: rd_data = shadow.stride;
			loop_pkg::REG_LIMIT:  rd_data = shadow.limit;
			loop_pkg::REG_STATUS: rd_data = {30'b0, done, busy};
			default: begin
				// Per-core result windows
				if (slot_ok && wb_req.adr[7:WIN_LO] == loop_pkg::REG_SUM_BASE[7:WIN_LO]) begin
					rd_data = sums[slot];
				end else if (slot_ok
						&& wb_req.adr[7:WIN_LO] == loop_pkg::REG_CNT_BASE[7:WIN_LO]) begin
					rd_data = loop_pkg::wb_dat_t'(counts[slot]);
				end
			end
		endcase
	end

	// Read data travels with the ack
	always_ff @(posedge clk) begin
		if (access) begin
			dat_q <= rd_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q      <= 1'b0;
			go_pend    <= 1'b0;
			fork_pulse <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			shadow     <= '0;
			cfg        <= '0;
		end else begin
			ack_q      <= access;
			go_pend    <= go_wr && !busy;
			fork_pulse <= go_pend;

			if (wr_en) begin
				case (wb_req.adr)
					loop_pkg::REG_START:
						shadow.start <= merge_bytes(shadow.start, wb_req.dat, wb_req.sel);
					loop_pkg::REG_STRIDE:
						shadow.stride <= merge_bytes(shadow.stride, wb_req.dat, wb_req.sel);
					loop_pkg::REG_LIMIT:
						shadow.limit <= merge_bytes(shadow.limit, wb_req.dat, wb_req.sel);
					default: ;
				endcase
			end

			// Fork edge snapshots the config, busy up and done down together
			if (go_pend) begin
				cfg  <= shadow;
				busy <= 1'b1;
				done <= 1'b0;
			end else if (busy && all_done && !fork_pulse) begin
				// Workers still show the old W_DONE during the fork cycle
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/loop_pkg.sv
`default_nettype none

package loop_pkg;

	// Largest core count that the result windows can address
	localparam int MAX_CORE = 8;

	// Loop index, also used for stride and limit
	typedef logic signed [31:0] idx_t;

	// Per-core index sum, wraps modulo 2^32
	typedef logic [31:0] acc_t;

	// Per-core iteration count
	typedef logic [15:0] cnt_t;

	// Wishbone field widths
	typedef logic [7:0]  wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
	} wb_req_t;

	typedef struct packed {
		logic    ack;
		wb_dat_t dat;
	} wb_rsp_t;

	typedef struct packed {
		idx_t start;
		idx_t stride;
		idx_t limit;
	} loop_cfg_t;

	// Register map, byte addresses
	localparam wb_adr_t REG_CTRL     = 8'h00;
	localparam wb_adr_t REG_START    = 8'h04;
	localparam wb_adr_t REG_STRIDE   = 8'h08;
	localparam wb_adr_t REG_LIMIT    = 8'h0C;
	localparam wb_adr_t REG_STATUS   = 8'h10;
	localparam wb_adr_t REG_SUM_BASE = 8'h20;
	localparam wb_adr_t REG_CNT_BASE = 8'h40;

	typedef enum logic [1:0] {
		W_IDLE,
		W_FETCH,
		W_WORK,
		W_DONE
	} worker_state_e;

endpackage

`default_nettype wire
